// File: Makefile
# Verilator flow for exec_core and its testbench

SIM_LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --assert --top-module exec_core \
		alu_pkg.sv alu.sv alu_sva.sv alu_control.sv regfile.sv exec_core.sv
	verilator --lint-only --timing --assert -f sim.f --top-module tb_exec_core

sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_exec_core -o tb_exec_core
	./obj_dir/tb_exec_core | tee $(SIM_LOG)
	grep -q "^>>> PASS$$" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

// File: alu.sv
/* Combinational 32-bit ALU, seven operations plus zero flag */
module alu
  import alu_pkg::*;
(
  input  logic [3:0]  ctl,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] out,
  output logic        zero
);

  always_comb begin
    case (ctl)
      ctl_and: out = a & b;
      ctl_or:  out = a | b;
      ctl_add: out = a + b; // Wraps without an overflow trap
      ctl_sub: out = a - b;
      ctl_slt: out = {31'd0, $signed(a) < $signed(b)};
      ctl_nor: out = ~(a | b);
      ctl_xor: out = a ^ b;
      default: out = 32'd0; // ctl_none and undefined codes
    endcase
  end

  assign zero = (out == 32'd0);

endmodule

// File: alu_control.sv
/* Instruction decoder: ALU control code, operand source,
   immediate extension, destination and write enable */
module alu_control
  import alu_pkg::*;
(
  input  instr_t      instr,
  output logic [3:0]  ctl,
  output logic        alu_src_imm,
  output logic [31:0] imm_ext,
  output logic [4:0]  dest,
  output logic        reg_write
);

  logic        known;
  logic [31:0] imm_sext;
  logic [31:0] imm_zext;

  assign imm_sext = {{16{instr.i.imm[15]}}, instr.i.imm};
  assign imm_zext = {16'd0, instr.i.imm};

  always_comb begin
    ctl         = ctl_none;
    alu_src_imm = 1'b0;
    imm_ext     = imm_zext;
    dest        = instr.i.rt; // I-type writes rt
    known       = 1'b1;
    case (instr.r.opcode)
      op_rtype: begin
        dest = instr.r.rd;
        case (instr.r.funct)
          fn_add:  ctl = ctl_add;
          fn_sub:  ctl = ctl_sub;
          fn_and:  ctl = ctl_and;
          fn_or:   ctl = ctl_or;
          fn_xor:  ctl = ctl_xor;
          fn_nor:  ctl = ctl_nor;
          fn_slt:  ctl = ctl_slt;
          default: known = 1'b0;
        endcase
      end
      op_addi: begin
        ctl         = ctl_add;
        alu_src_imm = 1'b1;
        imm_ext     = imm_sext;
      end
      op_slti: begin
        ctl         = ctl_slt;
        alu_src_imm = 1'b1;
        imm_ext     = imm_sext;
      end
      op_andi: begin
        ctl         = ctl_and;
        alu_src_imm = 1'b1;
      end
      op_ori: begin
        ctl         = ctl_or;
        alu_src_imm = 1'b1;
      end
      op_xori: begin
        ctl         = ctl_xor;
        alu_src_imm = 1'b1;
      end
      default: known = 1'b0;
    endcase
    // Writes to r0 are dropped here already
    reg_write = known && (dest != 5'd0);
  end

endmodule

// File: alu_pkg.sv
/* Shared ALU control codes, opcode and funct values,
   and the instruction word union */
package alu_pkg;

  // ALU control codes
  localparam logic [3:0] ctl_and  = 4'b0000;
  localparam logic [3:0] ctl_or   = 4'b0001;
  localparam logic [3:0] ctl_add  = 4'b0010;
  localparam logic [3:0] ctl_sub  = 4'b0110;
  localparam logic [3:0] ctl_slt  = 4'b0111;
  localparam logic [3:0] ctl_nor  = 4'b1100;
  localparam logic [3:0] ctl_xor  = 4'b1101;
  localparam logic [3:0] ctl_none = 4'b1111; // ALU output forced to zero

  // Primary opcodes
  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_addi  = 6'h08;
  localparam logic [5:0] op_slti  = 6'h0A;
  localparam logic [5:0] op_andi  = 6'h0C;
  localparam logic [5:0] op_ori   = 6'h0D;
  localparam logic [5:0] op_xori  = 6'h0E;

  // Funct field of R-type words
  localparam logic [5:0] fn_add = 6'h20;
  localparam logic [5:0] fn_sub = 6'h22;
  localparam logic [5:0] fn_and = 6'h24;
  localparam logic [5:0] fn_or  = 6'h25;
  localparam logic [5:0] fn_xor = 6'h26;
  localparam logic [5:0] fn_nor = 6'h27;
  localparam logic [5:0] fn_slt = 6'h2A;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt; // No shifts in this core
    logic [5:0] funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_t;

  // Same 32-bit word, two decodings
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_t;

endpackage

// File: alu_sva.sv
/* Immediate-assertion checker and coverage for the ALU,
   bound to every alu instance */
module alu_sva
  import alu_pkg::*;
(
  input logic [3:0]  ctl,
  input logic [31:0] a,
  input logic [31:0] b,
  input logic [31:0] out,
  input logic        zero
);

  logic [31:0] want_add;
  logic [31:0] want_sub;
  logic        want_lt;
  logic        add_ovf;
  logic        sub_ovf;

  always_comb begin
    want_add = a + b;
    want_sub = a - b;
    want_lt  = $signed(a) < $signed(b);

    // Signed overflow flags for coverage
    add_ovf = (a[31] == b[31]) && (want_add[31] != a[31]);
    sub_ovf = (a[31] != b[31]) && (want_sub[31] != a[31]);

    assert (zero === (out == 32'd0))
      else $error("alu: zero=%0b but out=%h", zero, out);

    case (ctl)
      ctl_add: assert (out == want_add)
                 else $error("alu add: a=%h b=%h out=%h", a, b, out);
      ctl_sub: assert (out == want_sub)
                 else $error("alu sub: a=%h b=%h out=%h", a, b, out);
      ctl_and: assert (out == (a & b))
                 else $error("alu and: a=%h b=%h out=%h", a, b, out);
      ctl_or:  assert (out == (a | b))
                 else $error("alu or: a=%h b=%h out=%h", a, b, out);
      ctl_xor: assert (out == (a ^ b))
                 else $error("alu xor: a=%h b=%h out=%h", a, b, out);
      ctl_nor: assert (out == ~(a | b))
                 else $error("alu nor: a=%h b=%h out=%h", a, b, out);
      ctl_slt: begin
        assert (out[31:1] == 31'd0)
          else $error("alu slt: upper bits set, out=%h", out);
        assert (out[0] == want_lt)
          else $error("alu slt: a=%h b=%h out=%h", a, b, out);
      end
      default: assert (out == 32'd0)
                 else $error("alu: ctl=%b should give 0, out=%h", ctl, out);
    endcase

    cover (ctl == ctl_and);
    cover (ctl == ctl_or);
    cover (ctl == ctl_add);
    cover (ctl == ctl_sub);
    cover (ctl == ctl_slt);
    cover (ctl == ctl_nor);
    cover (ctl == ctl_xor);
    cover (ctl == ctl_none);

    cover (ctl == ctl_add && zero); // a == -b
    cover (ctl == ctl_sub && zero); // Equal operands
    cover (ctl == ctl_and && zero);
    cover (ctl == ctl_nor && zero);
    cover (ctl == ctl_add && add_ovf);
    cover (ctl == ctl_sub && sub_ovf);
    cover (ctl == ctl_slt && want_lt);
    cover (ctl == ctl_slt && !want_lt);
    cover (ctl == ctl_slt && want_lt && (a[31] != b[31])); // Mixed signs
  end

endmodule

bind alu alu_sva u_alu_sva (.*);

// File: exec_core.sv
/* Two-stage execution core: decode and register read, then ALU,
   writeback and result strobe, with forwarding */
module exec_core
  import alu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_valid,
  input  instr_t      instr,
  output logic        result_valid,
  output logic [31:0] result,
  output logic        zero
);

  // Decode outputs
  logic [3:0]  dec_ctl;
  logic        dec_src_imm;
  logic [31:0] dec_imm;
  logic [4:0]  dec_dest;
  logic        dec_we;

  // Register file
  logic [31:0] rf_rd1;
  logic [31:0] rf_rd2;
  logic        rf_we;

  // Execute stage
  logic        ex_valid;
  logic [31:0] ex_a;
  logic [31:0] ex_b;
  logic [3:0]  ex_ctl;
  logic        ex_src_imm;
  logic [31:0] ex_imm;
  logic [4:0]  ex_dest;
  logic        ex_we;

  logic [31:0] fwd_a;
  logic [31:0] fwd_b;
  logic [31:0] alu_b;
  logic [31:0] alu_out;
  logic        alu_zero;

  alu_control u_ctrl (
    .instr       (instr),
    .ctl         (dec_ctl),
    .alu_src_imm (dec_src_imm),
    .imm_ext     (dec_imm),
    .dest        (dec_dest),
    .reg_write   (dec_we)
  );

  // Writeback lands on the same edge the next instruction reads
  assign rf_we = ex_valid && ex_we;

  regfile u_rf (
    .clk   (clk),
    .rst_n (rst_n),
    .ra1   (instr.r.rs),
    .ra2   (instr.r.rt),
    .wa    (ex_dest),
    .we    (rf_we),
    .wd    (alu_out),
    .rd1   (rf_rd1),
    .rd2   (rf_rd2)
  );

  // Bypass from execute when rf_we is set, which already excludes r0
  assign fwd_a = (rf_we && ex_dest == instr.r.rs) ? alu_out : rf_rd1;
  assign fwd_b = (rf_we && ex_dest == instr.r.rt) ? alu_out : rf_rd2;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
      ex_we    <= 1'b0;
    end else begin
      ex_valid <= instr_valid;
      ex_we    <= dec_we;
    end
  end

  always_ff @(posedge clk) begin
    ex_a       <= fwd_a;
    ex_b       <= fwd_b;
    ex_ctl     <= dec_ctl;
    ex_src_imm <= dec_src_imm;
    ex_imm     <= dec_imm;
    ex_dest    <= dec_dest;
  end

  assign alu_b = ex_src_imm ? ex_imm : ex_b;

  alu u_alu (
    .ctl  (ex_ctl),
    .a    (ex_a),
    .b    (alu_b),
    .out  (alu_out),
    .zero (alu_zero)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    result <= alu_out;
    zero   <= alu_zero;
  end

  a_no_spurious_result: assert property (
    @(posedge clk) disable iff (!rst_n)
    !instr_valid |-> ##2 !result_valid
  ) else $error("exec_core: result_valid without a matching strobe");

  // Decoder is the one that keeps r0 out of writeback
  a_no_r0_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    rf_we |-> (ex_dest != 5'd0)
  ) else $error("exec_core: writeback targets r0");

endmodule

// File: regfile.sv
/* 32 x 32-bit register file, two combinational read ports,
   one write port, r0 tied to zero */
module regfile (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  ra1,
  input  logic [4:0]  ra2,
  input  logic [4:0]  wa,
  input  logic        we,
  input  logic [31:0] wd,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (we && wa != 5'd0) begin
      regs[wa] <= wd;
    end
  end

  // Entry 0 is cleared at reset and never written
  assign rd1 = regs[ra1];
  assign rd2 = regs[ra2];

  a_r0_reads_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    (ra1 == 5'd0) |-> (rd1 == 32'd0)
  ) else $error("regfile: r0 read returned %h", rd1);

endmodule

// File: sim.f
alu_pkg.sv
alu.sv
alu_sva.sv
alu_control.sv
regfile.sv
exec_core.sv
tb_exec_core.sv

// File: tb_exec_core.sv
/* Testbench for exec_core: clock, reset, stimulus, reference model,
   result comparison and timeout */
module tb_exec_core
  import alu_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct {
    logic [31:0] res;
    logic        zero;
    int          due;
  } exp_t;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  instr_t      instr;
  logic        result_valid;
  logic [31:0] result;
  logic        zero;

  logic [31:0] model [32]; // Reference register file
  exp_t        exp_q[$];
  int          cycle = 0;
  int          issued = 0;
  int          seed = 26406;
  logic [5:0]  fn_list [7] = '{fn_add, fn_sub, fn_and, fn_or, fn_xor, fn_nor, fn_slt};

  exec_core dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .result_valid (result_valid),
    .result       (result),
    .zero         (zero)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "stopping on first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want)
      fail_stop($sformatf("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, want));
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want)
      fail_stop($sformatf("[FAIL] t=%0t %s: got %b, expected %b", $time, name, got, want));
  endtask

  function automatic instr_t rtype(input logic [5:0] fn, input logic [4:0] rd,
                                   input logic [4:0] rs, input logic [4:0] rt);
    instr_t ins;
    ins.r.opcode = op_rtype;
    ins.r.rs     = rs;
    ins.r.rt     = rt;
    ins.r.rd     = rd;
    ins.r.shamt  = 5'd0;
    ins.r.funct  = fn;
    return ins;
  endfunction

  function automatic instr_t itype(input logic [5:0] op, input logic [4:0] rt,
                                   input logic [4:0] rs, input logic [15:0] imm);
    instr_t ins;
    ins.i.opcode = op;
    ins.i.rs     = rs;
    ins.i.rt     = rt;
    ins.i.imm    = imm;
    return ins;
  endfunction

  // Expected result of one instruction against the model registers
  function automatic void ref_exec(input instr_t ins, output logic [31:0] res,
                                   output logic [4:0] wdest, output logic wen);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sx;
    logic [31:0] zx;
    logic        known;
    a     = model[ins.r.rs];
    b     = model[ins.r.rt];
    sx    = {{16{ins.i.imm[15]}}, ins.i.imm};
    zx    = {16'd0, ins.i.imm};
    known = 1'b1;
    res   = 32'd0;
    wdest = ins.i.rt;
    case (ins.r.opcode)
      op_rtype: begin
        wdest = ins.r.rd;
        case (ins.r.funct)
          fn_add:  res = a + b;
          fn_sub:  res = a - b;
          fn_and:  res = a & b;
          fn_or:   res = a | b;
          fn_xor:  res = a ^ b;
          fn_nor:  res = ~(a | b);
          fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: known = 1'b0;
        endcase
      end
      op_addi: res = a + sx;
      op_slti: res = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
      op_andi: res = a & zx;
      op_ori:  res = a | zx;
      op_xori: res = a ^ zx;
      default: known = 1'b0;
    endcase
    wen = known && (wdest != 5'd0);
  endfunction

  // Starts and returns on a falling edge
  task automatic issue(input instr_t ins, input int gap);
    exp_t        e;
    logic [4:0]  wdest;
    logic        wen;
    ref_exec(ins, e.res, wdest, wen);
    e.zero = (e.res == 32'd0);
    e.due  = cycle + 2;
    exp_q.push_back(e);
    if (wen)
      model[wdest] = e.res; // Model updates in issue order
    issued++;
    instr       = ins;
    instr_valid = 1'b1;
    @(negedge clk);
    instr_valid = 1'b0;
    instr       = '0;
    repeat (gap) @(negedge clk);
  endtask

  // No shifts, so 16 self-adds move the upper half into place
  task automatic load_wide(input logic [4:0] r, input logic [31:0] value, input int gap);
    issue(itype(op_addi, r, 5'd0, value[31:16]), 0);
    repeat (16) issue(rtype(fn_add, r, r, r), 0);
    issue(itype(op_ori, r, r, value[15:0]), gap);
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle > issued * 3 + 50)
      fail_stop($sformatf("Timeout at cycle %0d with %0d results pending", cycle, exp_q.size()));
  end

  always @(negedge clk) begin : compare
    exp_t e;
    if (rst_n && result_valid) begin
      if (exp_q.size() == 0) begin
        fail_stop("result_valid was high with no instruction outstanding");
      end else begin
        e = exp_q.pop_front();
        if (cycle != e.due)
          fail_stop($sformatf("Result came at cycle %0d, expected at cycle %0d", cycle, e.due));
        check_word("result", result, e.res);
        check_bit("zero", zero, e.zero);
      end
    end
  end

  initial begin : stimulus
    logic [31:0] rv;
    logic [2:0]  idx;
    int          drain;
    for (int k = 0; k < 32; k++) model[k] = 32'd0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // Idle after reset
    repeat (8) begin
      @(negedge clk);
      check_bit("result_valid", result_valid, 1'b0);
    end
    issue(rtype(fn_or, 5'd1, 5'd0, 5'd0), 1);

    // Immediates with sign and zero extension
    issue(itype(op_addi, 5'd1, 5'd0, 16'h1234), 1);
    issue(itype(op_addi, 5'd2, 5'd0, 16'hFFFB), 0);
    issue(itype(op_addi, 5'd3, 5'd0, 16'h7FFF), 1);
    issue(itype(op_addi, 5'd4, 5'd0, 16'h8000), 0);
    issue(itype(op_ori,  5'd5, 5'd0, 16'h8001), 1);
    issue(itype(op_andi, 5'd6, 5'd2, 16'hF0F0), 0);
    issue(itype(op_xori, 5'd7, 5'd2, 16'h8000), 1);
    issue(itype(op_slti, 5'd8, 5'd2, 16'h0001), 0);
    issue(itype(op_slti, 5'd9, 5'd1, 16'hFFFF), 1);

    // Two random wide operands and two near the signed limits
    rv = $random(seed);
    load_wide(5'd20, rv, 1);
    rv = $random(seed);
    load_wide(5'd21, rv, 0);
    rv = $random(seed);
    load_wide(5'd22, {16'h7FFF, rv[15:0]}, 1);
    load_wide(5'd23, {16'h8000, rv[31:16]}, 0);
    issue(rtype(fn_add, 5'd24, 5'd22, 5'd22), 0); // Add overflow
    issue(rtype(fn_sub, 5'd25, 5'd23, 5'd22), 1); // Sub overflow
    issue(rtype(fn_sub, 5'd26, 5'd22, 5'd23), 0);
    issue(rtype(fn_slt, 5'd27, 5'd23, 5'd22), 0); // Mixed signs
    issue(rtype(fn_slt, 5'd28, 5'd22, 5'd23), 1);
    issue(rtype(fn_slt, 5'd29, 5'd20, 5'd21), 0);

    // Random register-form operations with random gaps
    for (int k = 0; k < 40; k++) begin
      rv  = $random(seed);
      idx = rv[14:12] % 3'd7;
      issue(rtype(fn_list[idx], 5'd10 + {2'b0, rv[10:8]}, 5'd10 + {1'b0, rv[3:0]},
                  5'd10 + {1'b0, rv[7:4]}), int'(rv[16]));
    end

    // Back-to-back dependencies on rs, rt and both
    issue(itype(op_addi, 5'd11, 5'd0, 16'h0007), 0);
    issue(rtype(fn_add, 5'd12, 5'd11, 5'd0), 0);
    issue(rtype(fn_sub, 5'd13, 5'd0, 5'd12), 0);
    issue(rtype(fn_add, 5'd14, 5'd13, 5'd13), 0);
    issue(rtype(fn_nor, 5'd14, 5'd14, 5'd12), 2);

    // Register 0 and unknown encodings
    issue(itype(op_addi, 5'd0, 5'd0, 16'h0005), 0);
    issue(rtype(fn_add, 5'd18, 5'd0, 5'd0), 0);
    issue(rtype(fn_add, 5'd0, 5'd2, 5'd2), 1);
    issue(rtype(fn_or, 5'd15, 5'd0, 5'd0), 1);
    issue(rtype(6'h3F, 5'd2, 5'd2, 5'd2), 0);     // Unknown funct
    issue(itype(6'h3F, 5'd2, 5'd2, 16'h1234), 0); // Unknown opcode
    issue(rtype(fn_or, 5'd16, 5'd2, 5'd0), 1);

    drain = 0;
    while (exp_q.size() != 0 && drain < 8) begin
      @(negedge clk);
      drain++;
    end
    repeat (4) @(negedge clk);
    if (exp_q.size() != 0) begin
      fail_stop("Results still outstanding at end of test");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule
